// ==== include/core_cfg.svh ====
/*
 Widths, opcodes and ALU operation codes of the RV32I integer pipeline.
 Only OP, OP-IMM and LUI are decoded, and everything else counts as illegal.
 Forward selection codes follow the MEM/WB = 1, EX/MEM = 2 order of the mux.
*/
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data path and register index widths
`define CORE_XLEN       32
`define CORE_REG_IDX_W  5

// Major opcodes
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_OP_IMM 7'b0010011
`define CORE_OPC_LUI    7'b0110111

// funct3 field values
`define CORE_F3_ADD     3'b000
`define CORE_F3_SLL     3'b001
`define CORE_F3_SLT     3'b010
`define CORE_F3_SLTU    3'b011
`define CORE_F3_XOR     3'b100
`define CORE_F3_SR      3'b101
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111

// funct7 values, base and SUB/SRA variant
`define CORE_F7_BASE    7'b0000000
`define CORE_F7_ALT     7'b0100000

// ALU operation codes
`define CORE_ALU_OP_W   4
`define CORE_ALU_ADD    4'd0
`define CORE_ALU_SUB    4'd1
`define CORE_ALU_SLL    4'd2
`define CORE_ALU_SLT    4'd3
`define CORE_ALU_SLTU   4'd4
`define CORE_ALU_XOR    4'd5
`define CORE_ALU_SRL    4'd6
`define CORE_ALU_SRA    4'd7
`define CORE_ALU_OR     4'd8
`define CORE_ALU_AND    4'd9
`define CORE_ALU_LUI    4'd10

// Operand forward selections
`define CORE_FWD_NONE   2'b00
`define CORE_FWD_MEM_WB 2'b01
`define CORE_FWD_EX_MEM 2'b10

`endif

// ==== source/core_pkg.sv ====
/*
 Shared vector types of the integer pipeline.
 Widths come from the cfg header, so change them there only.
*/
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

	// One data word, used for operands, results and instructions
	typedef logic [`CORE_XLEN-1:0] word_t;

	// Integer register index, x0 to x31
	typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

	// ALU operation code, see CORE_ALU_* macros
	typedef logic [`CORE_ALU_OP_W-1:0] alu_op_t;

	// Forward mux select, see CORE_FWD_* macros
	typedef logic [1:0] fwd_sel_t;

endpackage

`default_nettype wire

// ==== source/int_decoder.sv ====
/*
 Combinational decode of RV32I OP, OP-IMM and LUI.
 Unknown opcodes and funct7 values are flagged illegal and never write.
 rs1/rs2 fields are passed on as-is even where the format has none.
*/
`default_nettype none

`include "core_cfg.svh"

module int_decoder import core_pkg::*; (
	input  word_t    instr,
	input  logic     instr_valid,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output word_t    imm,
	output logic     use_imm,
	output alu_op_t  alu_op,
	output logic     reg_wr,
	output logic     illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_base;
	logic       f7_alt;
	logic       known;

	// Instruction fields
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	assign f7_base = (funct7 == `CORE_F7_BASE);
	assign f7_alt  = (funct7 == `CORE_F7_ALT);

	always_comb begin
		alu_op  = `CORE_ALU_ADD;
		use_imm = 1'b0;
		imm     = '0;
		known   = 1'b1;
		case (opcode)
			`CORE_OPC_OP: begin
				// Only ADD/SUB and SRL/SRA accept the alternate funct7
				case (funct3)
					`CORE_F3_ADD:  alu_op = f7_alt ? `CORE_ALU_SUB : `CORE_ALU_ADD;
					`CORE_F3_SLL:  alu_op = `CORE_ALU_SLL;
					`CORE_F3_SLT:  alu_op = `CORE_ALU_SLT;
					`CORE_F3_SLTU: alu_op = `CORE_ALU_SLTU;
					`CORE_F3_XOR:  alu_op = `CORE_ALU_XOR;
					`CORE_F3_SR:   alu_op = f7_alt ? `CORE_ALU_SRA : `CORE_ALU_SRL;
					`CORE_F3_OR:   alu_op = `CORE_ALU_OR;
					default:       alu_op = `CORE_ALU_AND;
				endcase
				if (funct3 == `CORE_F3_ADD || funct3 == `CORE_F3_SR)
					known = f7_base || f7_alt;
				else
					known = f7_base;
			end
			`CORE_OPC_OP_IMM: begin
				use_imm = 1'b1;
				// Sign-extended I immediate
				imm = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
				case (funct3)
					`CORE_F3_ADD:  alu_op = `CORE_ALU_ADD;
					`CORE_F3_SLL:  alu_op = `CORE_ALU_SLL;
					`CORE_F3_SLT:  alu_op = `CORE_ALU_SLT;
					`CORE_F3_SLTU: alu_op = `CORE_ALU_SLTU;
					`CORE_F3_XOR:  alu_op = `CORE_ALU_XOR;
					`CORE_F3_SR:   alu_op = f7_alt ? `CORE_ALU_SRA : `CORE_ALU_SRL;
					`CORE_F3_OR:   alu_op = `CORE_ALU_OR;
					default:       alu_op = `CORE_ALU_AND;
				endcase
				// funct7 only matters for the shift-immediate forms
				if (funct3 == `CORE_F3_SLL)
					known = f7_base;
				else if (funct3 == `CORE_F3_SR)
					known = f7_base || f7_alt;
			end
			`CORE_OPC_LUI: begin
				use_imm = 1'b1;
				alu_op  = `CORE_ALU_LUI;
				// U immediate, low 12 bits zero
				imm     = {instr[31:12], 12'b0};
			end
			default: known = 1'b0;
		endcase
	end

	// Writes to x0 are dropped here, so later stages never see them
	assign reg_wr  = instr_valid && known && (rd != '0);
	assign illegal = instr_valid && !known;

endmodule

`default_nettype wire

// ==== source/int_regfile.sv ====
/*
 32 x 32 integer register file, x0 hard-wired to zero.
 Reads are combinational; a read of the register being written
 returns the new data in the same cycle.
*/
`default_nettype none

module int_regfile import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	output word_t    rs1_data,
	output word_t    rs2_data
);

	// Entry 0 exists but is never written
	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Read port 1 with write-through
	always_comb begin
		if (rs1 == '0)
			rs1_data = '0;
		else if (wr_en && wr_idx == rs1)
			rs1_data = wr_data;
		else
			rs1_data = regs[rs1];
	end

	// Read port 2 with write-through
	always_comb begin
		if (rs2 == '0)
			rs2_data = '0;
		else if (wr_en && wr_idx == rs2)
			rs2_data = wr_data;
		else
			rs2_data = regs[rs2];
	end

endmodule

`default_nettype wire

// ==== source/id_ex_reg.sv ====
/*
 ID/EX pipeline register, one decoded instruction for the EX stage.
 Only the write enable and illegal flag are reset; a cleared stage is a bubble.
*/
`default_nettype none

module id_ex_reg import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     illegal,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  reg_idx_t rd,
	input  word_t    rs1_data,
	input  word_t    rs2_data,
	input  word_t    imm,
	input  logic     use_imm,
	input  alu_op_t  alu_op,
	input  logic     reg_wr,
	output logic     ex_illegal,
	output reg_idx_t ex_rs1,
	output reg_idx_t ex_rs2,
	output reg_idx_t ex_rd,
	output word_t    ex_rs1_data,
	output word_t    ex_rs2_data,
	output word_t    ex_imm,
	output logic     ex_use_imm,
	output alu_op_t  ex_alu_op,
	output logic     ex_reg_wr
);

	// Control bits
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_reg_wr  <= 1'b0;
			ex_illegal <= 1'b0;
		end else begin
			ex_reg_wr  <= reg_wr;
			ex_illegal <= illegal;
		end
	end

	// Operands and decoded fields
	always_ff @(posedge clk) begin
		ex_rs1      <= rs1;
		ex_rs2      <= rs2;
		ex_rd       <= rd;
		ex_rs1_data <= rs1_data;
		ex_rs2_data <= rs2_data;
		ex_imm      <= imm;
		ex_use_imm  <= use_imm;
		ex_alu_op   <= alu_op;
	end

endmodule

`default_nettype wire

// ==== source/int_forward.sv ====
/*
 Integer forwarding for the two EX operands.
 EX/MEM wins over MEM/WB; x0 and non-writing stages are never forwarded.
 Distance three is covered by the register file write-through.
*/
`default_nettype none

`include "core_cfg.svh"

module int_forward import core_pkg::*; (
	input  reg_idx_t ex_rs1,
	input  reg_idx_t ex_rs2,
	input  word_t    ex_rs1_data,
	input  word_t    ex_rs2_data,
	input  reg_idx_t mem_rd,
	input  logic     mem_reg_wr,
	input  word_t    mem_result,
	input  reg_idx_t wb_rd,
	input  logic     wb_reg_wr,
	input  word_t    wb_result,
	output word_t    op_a,
	output word_t    op_b
);

	fwd_sel_t sel_a;
	fwd_sel_t sel_b;

	// Newest producer of src, or none
	function automatic fwd_sel_t pick(input reg_idx_t src);
		if (src == '0)
			return `CORE_FWD_NONE;
		if (mem_reg_wr && mem_rd == src)
			return `CORE_FWD_EX_MEM;
		if (wb_reg_wr && wb_rd == src)
			return `CORE_FWD_MEM_WB;
		return `CORE_FWD_NONE;
	endfunction

	// Operand mux driven by a select
	function automatic word_t mux(input fwd_sel_t sel, input word_t reg_val);
		case (sel)
			`CORE_FWD_EX_MEM: return mem_result;
			`CORE_FWD_MEM_WB: return wb_result;
			default:          return reg_val;
		endcase
	endfunction

	assign sel_a = pick(ex_rs1);
	assign sel_b = pick(ex_rs2);

	assign op_a = mux(sel_a, ex_rs1_data);
	assign op_b = mux(sel_b, ex_rs2_data);

endmodule

`default_nettype wire

// ==== source/int_alu.sv ====
/*
 Combinational RV32I integer ALU.
 Shifts use the low five bits of the second operand.
 No overflow flag; results simply wrap.
*/
`default_nettype none

`include "core_cfg.svh"

module int_alu import core_pkg::*; (
	input  word_t   op_a,
	input  word_t   op_b,
	input  word_t   imm,
	input  logic    use_imm,
	input  alu_op_t alu_op,
	output word_t   result
);

	word_t      src_b;
	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// Immediate replaces rs2 for OP-IMM and LUI
	assign src_b = use_imm ? imm : op_b;
	assign shamt = src_b[4:0];

	// Compare results for SLT/SLTU
	assign lt_signed   = $signed(op_a) < $signed(src_b);
	assign lt_unsigned = op_a < src_b;

	always_comb begin
		case (alu_op)
			`CORE_ALU_ADD:  result = op_a + src_b;
			`CORE_ALU_SUB:  result = op_a - src_b;
			`CORE_ALU_SLL:  result = op_a << shamt;
			`CORE_ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
			`CORE_ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
			`CORE_ALU_XOR:  result = op_a ^ src_b;
			`CORE_ALU_SRL:  result = op_a >> shamt;
			// Arithmetic shift keeps the sign bit
			`CORE_ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
			`CORE_ALU_OR:   result = op_a | src_b;
			`CORE_ALU_AND:  result = op_a & src_b;
			// U immediate goes straight through
			`CORE_ALU_LUI:  result = imm;
			default:        result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/ex_wb_regs.sv ====
/*
 EX/MEM and MEM/WB pipeline registers.
 MEM/WB drives writeback and both stages feed forwarding.
 illegal_instr is registered from the EX-stage flag, one stage after ID/EX.
*/
`default_nettype none

module ex_wb_regs import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t ex_rd,
	input  logic     ex_reg_wr,
	input  logic     ex_illegal,
	input  word_t    result,
	output reg_idx_t mem_rd,
	output logic     mem_reg_wr,
	output word_t    mem_result,
	output reg_idx_t wb_rd,
	output logic     wb_reg_wr,
	output word_t    wb_result,
	output logic     illegal_instr
);

	// Write enables and illegal pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_reg_wr    <= 1'b0;
			wb_reg_wr     <= 1'b0;
			illegal_instr <= 1'b0;
		end else begin
			mem_reg_wr    <= ex_reg_wr;
			wb_reg_wr     <= mem_reg_wr;
			illegal_instr <= ex_illegal;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		mem_rd     <= ex_rd;
		mem_result <= result;
	end

	// MEM/WB payload, no memory access in between
	always_ff @(posedge clk) begin
		wb_rd     <= mem_rd;
		wb_result <= mem_result;
	end

endmodule

`default_nettype wire

// ==== source/rv32i_core.sv ====
/*
 Three-stage RV32I integer pipeline, ID/EX, EX/MEM, MEM/WB.
 Always accepts; instr_valid low inserts a bubble.
 A result shows on wb_* three cycles after acceptance and is written
 into the register file on the following edge.
*/
`default_nettype none

module rv32i_core import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  word_t    instr,
	input  logic     instr_valid,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_data,
	output logic     illegal_instr
);

	// Decode stage
	reg_idx_t dec_rs1;
	reg_idx_t dec_rs2;
	reg_idx_t dec_rd;
	word_t    dec_imm;
	logic     dec_use_imm;
	alu_op_t  dec_alu_op;
	logic     dec_reg_wr;
	logic     dec_illegal;
	word_t    rf_rs1_data;
	word_t    rf_rs2_data;

	// Execute stage
	logic     ex_illegal;
	reg_idx_t ex_rs1;
	reg_idx_t ex_rs2;
	reg_idx_t ex_rd;
	word_t    ex_rs1_data;
	word_t    ex_rs2_data;
	word_t    ex_imm;
	logic     ex_use_imm;
	alu_op_t  ex_alu_op;
	logic     ex_reg_wr;
	word_t    op_a;
	word_t    op_b;
	word_t    alu_result;

	// Memory stage, forwarding source only
	reg_idx_t mem_rd;
	logic     mem_reg_wr;
	word_t    mem_result;

	int_decoder i_decoder (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rs1         (dec_rs1),
		.rs2         (dec_rs2),
		.rd          (dec_rd),
		.imm         (dec_imm),
		.use_imm     (dec_use_imm),
		.alu_op      (dec_alu_op),
		.reg_wr      (dec_reg_wr),
		.illegal     (dec_illegal)
	);

	// Written straight from MEM/WB
	int_regfile i_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1      (dec_rs1),
		.rs2      (dec_rs2),
		.wr_en    (wb_valid),
		.wr_idx   (wb_rd),
		.wr_data  (wb_data),
		.rs1_data (rf_rs1_data),
		.rs2_data (rf_rs2_data)
	);

	id_ex_reg i_id_ex (
		.clk         (clk),
		.rst         (rst),
		.illegal     (dec_illegal),
		.rs1         (dec_rs1),
		.rs2         (dec_rs2),
		.rd          (dec_rd),
		.rs1_data    (rf_rs1_data),
		.rs2_data    (rf_rs2_data),
		.imm         (dec_imm),
		.use_imm     (dec_use_imm),
		.alu_op      (dec_alu_op),
		.reg_wr      (dec_reg_wr),
		.ex_illegal  (ex_illegal),
		.ex_rs1      (ex_rs1),
		.ex_rs2      (ex_rs2),
		.ex_rd       (ex_rd),
		.ex_rs1_data (ex_rs1_data),
		.ex_rs2_data (ex_rs2_data),
		.ex_imm      (ex_imm),
		.ex_use_imm  (ex_use_imm),
		.ex_alu_op   (ex_alu_op),
		.ex_reg_wr   (ex_reg_wr)
	);

	int_forward i_forward (
		.ex_rs1      (ex_rs1),
		.ex_rs2      (ex_rs2),
		.ex_rs1_data (ex_rs1_data),
		.ex_rs2_data (ex_rs2_data),
		.mem_rd      (mem_rd),
		.mem_reg_wr  (mem_reg_wr),
		.mem_result  (mem_result),
		.wb_rd       (wb_rd),
		.wb_reg_wr   (wb_valid),
		.wb_result   (wb_data),
		.op_a        (op_a),
		.op_b        (op_b)
	);

	int_alu i_alu (
		.op_a    (op_a),
		.op_b    (op_b),
		.imm     (ex_imm),
		.use_imm (ex_use_imm),
		.alu_op  (ex_alu_op),
		.result  (alu_result)
	);

	// MEM/WB outputs are the writeback port
	ex_wb_regs i_ex_wb (
		.clk           (clk),
		.rst           (rst),
		.ex_rd         (ex_rd),
		.ex_reg_wr     (ex_reg_wr),
		.ex_illegal    (ex_illegal),
		.result        (alu_result),
		.mem_rd        (mem_rd),
		.mem_reg_wr    (mem_reg_wr),
		.mem_result    (mem_result),
		.wb_rd         (wb_rd),
		.wb_reg_wr     (wb_valid),
		.wb_result     (wb_data),
		.illegal_instr (illegal_instr)
	);

endmodule

`default_nettype wire

// ==== verification/core_props.sv ====
/*
 Concurrent checks on rv32i_core, bound into every instance.
 illegal_instr is expected two edges after the illegal instruction is accepted.
*/
`default_nettype none

module core_props import core_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     dec_illegal,
	input logic     wb_valid,
	input reg_idx_t wb_rd,
	input logic     illegal_instr
);

	// No writeback ever targets x0
	wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> wb_rd != '0)
		else $error("wb_valid high with wb_rd equal to x0");

	// Outputs quiet once reset has been seen on two edges
	reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !wb_valid && !illegal_instr)
		else $error("wb_valid or illegal_instr high during reset");

	// Illegal decode at edge N, pulse visible after edge N+1
	illegal_pulse: assert property (@(posedge clk) disable iff (rst)
		$past(dec_illegal, 2) |-> illegal_instr)
		else $error("illegal instruction without an illegal_instr pulse");

endmodule

bind rv32i_core core_props i_props (
	.clk           (clk),
	.rst           (rst),
	.dec_illegal   (dec_illegal),
	.wb_valid      (wb_valid),
	.wb_rd         (wb_rd),
	.illegal_instr (illegal_instr)
);

`default_nettype wire

// ==== verification/tb_rv32i_core.sv ====
/*
 Directed and random tests of rv32i_core against a shadow register model.
 Writebacks expected on the port after the third edge following acceptance,
 illegal_instr after the second. Random stream seeded with 31.
*/
`default_nettype none

`include "core_cfg.svh"

module tb_rv32i_core import core_pkg::*; ();

	typedef struct packed {
		int unsigned edge_no;
		reg_idx_t    rd;
		word_t       data;
	} wb_exp_t;

	logic     clk;
	logic     rst;
	word_t    instr;
	logic     instr_valid;
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_data;
	logic     illegal_instr;

	word_t       shadow [32];
	wb_exp_t     wb_q [$];
	int unsigned ill_q [$];
	int unsigned edge_cnt = 0;
	int          errors = 0;
	int          checks = 0;

	rv32i_core i_dut (
		.clk           (clk),
		.rst           (rst),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.illegal_instr (illegal_instr)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) edge_cnt <= edge_cnt + 1;

	task automatic check(input string name, input word_t act, input word_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: actual %h expected %h", $time, name, act, exp);
		end
	endtask

	// Port monitor sampled mid-cycle
	always @(negedge clk) begin
		if (edge_cnt > 0) begin
			if (wb_q.size() > 0 && wb_q[0].edge_no == edge_cnt) begin
				check("wb_valid", word_t'(wb_valid), 32'd1);
				check("wb_rd", word_t'(wb_rd), word_t'(wb_q[0].rd));
				check("wb_data", wb_data, wb_q[0].data);
				void'(wb_q.pop_front());
			end else begin
				check("wb_valid", word_t'(wb_valid), 32'd0);
			end
			if (ill_q.size() > 0 && ill_q[0] == edge_cnt) begin
				check("illegal_instr", word_t'(illegal_instr), 32'd1);
				void'(ill_q.pop_front());
			end else begin
				check("illegal_instr", word_t'(illegal_instr), 32'd0);
			end
		end
	end

	// ISA-level result of OP, OP-IMM and LUI
	function automatic word_t model_alu(input word_t ins, input word_t a, input word_t b);
		word_t      src2;
		logic       is_imm;
		logic [4:0] sh;
		if (ins[6:0] == `CORE_OPC_LUI)
			return {ins[31:12], 12'h000};
		is_imm = (ins[6:0] == `CORE_OPC_OP_IMM);
		src2 = is_imm ? {{20{ins[31]}}, ins[31:20]} : b;
		sh = src2[4:0];
		case (ins[14:12])
			3'd0: return (!is_imm && ins[30]) ? a - src2 : a + src2;
			3'd1: return a << sh;
			3'd2: return ($signed(a) < $signed(src2)) ? 32'd1 : 32'd0;
			3'd3: return (a < src2) ? 32'd1 : 32'd0;
			3'd4: return a ^ src2;
			// SRA vs SRL by instruction bit 30
			3'd5: return ins[30] ? word_t'($signed(a) >>> sh) : a >> sh;
			3'd6: return a | src2;
			default: return a & src2;
		endcase
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd);
		return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
		return {imm, rd, `CORE_OPC_LUI};
	endfunction

	// Small register range for more hazards
	function automatic reg_idx_t rnd_reg();
		return reg_idx_t'($urandom_range(7));
	endfunction

	// One slot driven just after the rising edge
	task automatic drive(input logic valid, input word_t ins);
		@(posedge clk);
		#10;
		instr       = ins;
		instr_valid = valid;
	endtask

	// Junk on instr while invalid
	task automatic bubble();
		drive(1'b0, word_t'($urandom));
	endtask

	// Legal instruction with shadow update and expected writeback
	task automatic issue(input word_t ins);
		word_t   res;
		wb_exp_t item;
		drive(1'b1, ins);
		res = model_alu(ins, shadow[ins[19:15]], shadow[ins[24:20]]);
		if (ins[11:7] != 5'd0) begin
			shadow[ins[11:7]] = res;
			item.edge_no = edge_cnt + 3;
			item.rd = ins[11:7];
			item.data = res;
			wb_q.push_back(item);
		end
	endtask

	task automatic issue_illegal(input word_t ins);
		drive(1'b1, ins);
		ill_q.push_back(edge_cnt + 2);
	endtask

	// LUI plus ADDI with the low half sign-extended
	task automatic load(input reg_idx_t rd, input word_t val);
		word_t hi;
		hi = val + 32'h800;
		issue(enc_u(hi[31:12], rd));
		issue(enc_i(val[11:0], rd, 3'd0, rd));
	endtask

	task automatic drain();
		int n;
		bubble();
		n = 0;
		while ((wb_q.size() > 0 || ill_q.size() > 0) && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (wb_q.size() > 0 || ill_q.size() > 0) begin
			errors++;
			$display("Timeout: expected results still pending after %0d cycles", n);
			wb_q.delete();
			ill_q.delete();
		end
	endtask

	task automatic report(input string name, input int err0);
		$display("Test %s: %s (%0d errors)", name,
			(errors == err0) ? "ok" : "mismatches", errors - err0);
	endtask

	task automatic test_idle();
		int err0;
		err0 = errors;
		repeat (6) bubble();
		drain();
		report("idle", err0);
	endtask

	task automatic test_reg_reg();
		word_t ops_a [5];
		word_t ops_b [5];
		int    err0;
		ops_a = '{32'h7fffffff, 32'hffffffff, 32'h12345678, 32'h80000000, 32'hdeadbeef};
		ops_b = '{32'h80000000, 32'h00000001, 32'h12345678, 32'h0000001f, 32'h00000000};
		err0 = errors;
		for (int p = 0; p < 5; p++) begin
			load(5'd1, ops_a[p]);
			load(5'd2, ops_b[p]);
			for (int f = 0; f < 8; f++)
				issue(enc_r(7'h00, 5'd2, 5'd1, 3'(f), reg_idx_t'(f + 3)));
			// SUB and SRA
			issue(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11));
			issue(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd12));
		end
		drain();
		report("reg_reg", err0);
	endtask

	task automatic test_reg_imm();
		int err0;
		err0 = errors;
		load(5'd1, 32'h80000f0f);
		issue(enc_i(12'hfff, 5'd1, 3'd0, 5'd3));
		issue(enc_i(12'h800, 5'd1, 3'd0, 5'd4));
		issue(enc_i(12'h7ff, 5'd1, 3'd0, 5'd5));
		// SLTI and SLTIU with -1
		issue(enc_i(12'hfff, 5'd1, 3'd2, 5'd6));
		issue(enc_i(12'hfff, 5'd1, 3'd3, 5'd7));
		issue(enc_i(12'h800, 5'd1, 3'd4, 5'd8));
		issue(enc_i(12'h0f0, 5'd1, 3'd6, 5'd9));
		issue(enc_i(12'hf0f, 5'd1, 3'd7, 5'd10));
		// SLLI 31, SRLI 0, SRAI 31, SRAI 4
		issue(enc_i(12'h01f, 5'd1, 3'd1, 5'd11));
		issue(enc_i(12'h000, 5'd1, 3'd5, 5'd12));
		issue(enc_i(12'h41f, 5'd1, 3'd5, 5'd13));
		issue(enc_i(12'h404, 5'd1, 3'd5, 5'd14));
		issue(enc_u(20'hfffff, 5'd15));
		issue(enc_u(20'h12345, 5'd16));
		drain();
		report("reg_imm", err0);
	endtask

	// Distance 1 EX/MEM, 2 MEM/WB, 3 regfile bypass, 4 plain read
	task automatic test_forward();
		int err0;
		err0 = errors;
		for (int d = 1; d <= 4; d++) begin
			for (int b = 0; b < 2; b++) begin
				issue(enc_i(12'(d * 17 + b), 5'd0, 3'd0, 5'd20));
				for (int k = 1; k < d; k++) begin
					if (b != 0)
						bubble();
					else
						issue(enc_i(12'h055, 5'd21, 3'd4, 5'd21));
				end
				issue(enc_r(7'h00, 5'd20, 5'd20, 3'd0, 5'd22));
				issue(enc_r(7'h20, 5'd22, 5'd20, 3'd0, 5'd23));
			end
		end
		// Back-to-back chain on one register
		repeat (6) issue(enc_i(12'h003, 5'd24, 3'd0, 5'd24));
		drain();
		report("forward", err0);
	endtask

	task automatic test_x0_illegal();
		int err0;
		err0 = errors;
		issue(enc_i(12'h005, 5'd0, 3'd0, 5'd0));
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd25));
		load(5'd26, 32'h0badf00d);
		// Unknown opcode, MUL funct7, bad SLLI funct7
		issue_illegal({17'd0, 3'd0, 5'd26, 7'h7f});
		issue_illegal(enc_r(7'h01, 5'd26, 5'd26, 3'd0, 5'd26));
		issue_illegal(enc_i(12'h401, 5'd26, 3'd1, 5'd26));
		issue(enc_r(7'h00, 5'd0, 5'd26, 3'd0, 5'd27));
		drain();
		report("x0_illegal", err0);
	endtask

	task automatic test_random();
		word_t       ins;
		logic [11:0] imm;
		logic [2:0]  f3;
		logic        alt;
		int          err0;
		err0 = errors;
		for (int n = 0; n < 200; n++) begin
			if ($urandom_range(3) == 0)
				bubble();
			f3  = 3'($urandom_range(7));
			alt = 1'($urandom_range(1));
			case ($urandom_range(2))
				0: ins = enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
					rnd_reg(), rnd_reg(), f3, rnd_reg());
				1: begin
					imm = 12'($urandom);
					// Shift forms need a legal funct7
					if (f3 == 3'd1)
						imm[11:5] = 7'h00;
					else if (f3 == 3'd5)
						imm[11:5] = alt ? 7'h20 : 7'h00;
					ins = enc_i(imm, rnd_reg(), f3, rnd_reg());
				end
				default: ins = enc_u(20'($urandom), rnd_reg());
			endcase
			issue(ins);
		end
		drain();
		report("random", err0);
	endtask

	initial begin
		void'($urandom(31));
		foreach (shadow[i])
			shadow[i] = '0;
		rst         = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		repeat (8) @(posedge clk);
		#10;
		rst = 1'b0;
		test_idle();
		test_reg_reg();
		test_reg_imm();
		test_forward();
		test_x0_illegal();
		test_random();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#2000000;
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/core_pkg.sv
source/int_decoder.sv
source/int_regfile.sv
source/id_ex_reg.sv
source/int_forward.sv
source/int_alu.sv
source/ex_wb_regs.sv
source/rv32i_core.sv
verification/core_props.sv
verification/tb_rv32i_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the rv32i_core testbench with Verilator
# Exit status 0 only when the log holds no failure report

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f flist.f \
	--top-module tb_rv32i_core -Mdir "$OBJ" -o tb_rv32i_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/tb_rv32i_core" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "No pass report found in $LOG"
	exit 1
fi
exit 0
